/* hw/etx_pkg.sv */
`default_nettype none

package etx_pkg;

   // ######################################
   // Transfer size and packet layout
   // ######################################

   // Transfer size of one access
   typedef enum logic [1:0] {
      dm_byte   = 2'd0,
      dm_half   = 2'd1,
      dm_word   = 2'd2,
      dm_double = 2'd3
   } datamode_t;

   // One queued packet, 104 bits in total
   typedef struct packed {
      logic        write;
      datamode_t   datamode;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
      logic        spare;
   } emesh_packet_t;

   // One link cycle with frame and data lanes
   typedef struct packed {
      logic        frame;
      logic [15:0] data;
   } link_word_t;

   // ######################################
   // Framer states and register map
   // ######################################

   // Three header words, then four data words
   typedef enum logic [2:0] {
      tx_idle,
      tx_hdr1,
      tx_hdr2,
      tx_hdr3,
      tx_dat1,
      tx_dat2,
      tx_dat3,
      tx_dat4
   } tx_state_t;

   // Word addresses, byte offset divided by four
   typedef enum logic [2:0] {
      reg_dstaddr = 3'd0,
      reg_srcaddr = 3'd1,
      reg_data    = 3'd2,
      reg_ctrl    = 3'd3,
      reg_status  = 3'd4
   } wb_reg_t;

endpackage

`default_nettype wire

/* hw/etx_wb_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_wb_slave #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire                          tx_lclk,
   input  wire                          reset,
   input  wire                          wb_cyc,
   input  wire                          wb_stb,
   input  wire                          wb_we,
   input  wire [2:0]                    wb_adr,
   input  wire [31:0]                   wb_dat_w,
   input  wire                          fifo_full,
   input  wire [$clog2(FIFO_DEPTH):0]   fifo_count,
   input  wire                          tx_wait,
   output logic [31:0]                  wb_dat_r,
   output logic                         wb_ack,
   output logic                         push,
   output etx_pkg::emesh_packet_t       push_pkt
);

   // Field registers
   logic [31:0]      dstaddr_q;
   logic [31:0]      srcaddr_q;
   logic [31:0]      data_q;
   logic [7:0]       ctrl_q;

   etx_pkg::wb_reg_t reg_sel;
   logic             req;
   logic             ctrl_wr;
   logic [31:0]      status;
   logic [31:0]      rd_mux;

   assign reg_sel = etx_pkg::wb_reg_t'(wb_adr);

   // Live request, masked in the ack cycle
   assign req     = wb_cyc & wb_stb & ~wb_ack;
   assign ctrl_wr = req & wb_we & (reg_sel == etx_pkg::reg_ctrl);

   // Push only when there is room
   assign push = ctrl_wr & ~fifo_full;

   // ######################################
   // Packet assembly
   // ######################################

   always_comb
   begin
      push_pkt          = '0;
      // Control bits straight from the bus
      push_pkt.write    = wb_dat_w[0];
      push_pkt.datamode = etx_pkg::datamode_t'(wb_dat_w[2:1]);
      push_pkt.ctrlmode = wb_dat_w[7:4];
      push_pkt.dstaddr  = dstaddr_q;
      push_pkt.data     = data_q;
      push_pkt.srcaddr  = srcaddr_q;
   end

   // Ack a cycle later, ctrl writes wait for room
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
         wb_ack <= 1'b0;
      else if (ctrl_wr)
         wb_ack <= ~fifo_full;
      else
         wb_ack <= req;
   end

   // Field stores
   always_ff @(posedge tx_lclk)
   begin
      if (req && wb_we)
      begin
         unique case (reg_sel)
            etx_pkg::reg_dstaddr: dstaddr_q <= wb_dat_w;
            etx_pkg::reg_srcaddr: srcaddr_q <= wb_dat_w;
            etx_pkg::reg_data:    data_q    <= wb_dat_w;
            // Last control word kept for readback
            etx_pkg::reg_ctrl:    if (!fifo_full) ctrl_q <= wb_dat_w[7:0];
            default: ;
         endcase
      end
   end

   // ######################################
   // Readback
   // ######################################

   always_comb
   begin
      status                          = '0;
      status[$clog2(FIFO_DEPTH):0]    = fifo_count;
      // Pushback as seen after the synchronizer
      status[8]                       = tx_wait;
   end

   always_comb
   begin
      unique case (reg_sel)
         etx_pkg::reg_dstaddr: rd_mux = dstaddr_q;
         etx_pkg::reg_srcaddr: rd_mux = srcaddr_q;
         etx_pkg::reg_data:    rd_mux = data_q;
         etx_pkg::reg_ctrl:    rd_mux = {24'd0, ctrl_q};
         etx_pkg::reg_status:  rd_mux = status;
         default:              rd_mux = '0;
      endcase
   end

   // Same latency as a field write
   always_ff @(posedge tx_lclk)
   begin
      if (req && !wb_we)
         wb_dat_r <= rd_mux;
   end

endmodule

`default_nettype wire

/* hw/etx_packet_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_packet_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire                           tx_lclk,
   input  wire                           reset,
   input  wire                           push,
   input  etx_pkg::emesh_packet_t        push_pkt,
   input  wire                           pop,
   output etx_pkg::emesh_packet_t        head_pkt,
   output logic                          empty,
   output logic                          full,
   output logic [$clog2(FIFO_DEPTH):0]   count
);

   localparam int AW = $clog2(FIFO_DEPTH);

   // Packet storage
   etx_pkg::emesh_packet_t mem [FIFO_DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic          do_push;
   logic          do_pop;

   // Guard against misuse at the edges
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign empty = (count == '0);
   assign full  = (count == FIFO_DEPTH[AW:0]);

   // Head visible before the pop
   assign head_pkt = mem[rd_ptr];

   // ######################################
   // Storage and pointers
   // ######################################

   always_ff @(posedge tx_lclk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_pkt;
   end

   // Pointers wrap on power-of-two depth
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Occupancy
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/etx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_framer (
   input  wire                     tx_lclk,
   input  wire                     reset,
   input  wire                     empty,
   input  etx_pkg::emesh_packet_t  head_pkt,
   input  wire                     tx_wait,
   output logic                    pop,
   output etx_pkg::link_word_t     link_word
);

   etx_pkg::tx_state_t     state;
   etx_pkg::tx_state_t     state_nxt;
   etx_pkg::emesh_packet_t cur_pkt;

   logic [47:0] header;
   logic        start;
   logic        burst_ok;

   // ######################################
   // Header and burst decision
   // ######################################

   // Header, most significant end first
   assign header = {~cur_pkt.write, 7'd0, cur_pkt.ctrlmode, cur_pkt.dstaddr,
                    cur_pkt.datamode, cur_pkt.write, 1'b1};

   // New packet from idle
   assign start = (state == etx_pkg::tx_idle) & ~empty & ~tx_wait;

   // Consecutive write with the same modes
   assign burst_ok = ~empty & ~tx_wait
                   & cur_pkt.write & head_pkt.write
                   & (head_pkt.ctrlmode == cur_pkt.ctrlmode)
                   & (head_pkt.datamode == cur_pkt.datamode)
                   & (head_pkt.dstaddr == cur_pkt.dstaddr + 32'd8);

   // Pop in the load cycle
   assign pop = start | ((state == etx_pkg::tx_dat4) & burst_ok);

   // ######################################
   // State machine
   // ######################################

   always_comb
   begin
      unique case (state)
         etx_pkg::tx_idle: state_nxt = start ? etx_pkg::tx_hdr1 : etx_pkg::tx_idle;
         etx_pkg::tx_hdr1: state_nxt = etx_pkg::tx_hdr2;
         etx_pkg::tx_hdr2: state_nxt = etx_pkg::tx_hdr3;
         etx_pkg::tx_hdr3: state_nxt = etx_pkg::tx_dat1;
         etx_pkg::tx_dat1: state_nxt = etx_pkg::tx_dat2;
         etx_pkg::tx_dat2: state_nxt = etx_pkg::tx_dat3;
         etx_pkg::tx_dat3: state_nxt = etx_pkg::tx_dat4;
         // Burst skips the header
         etx_pkg::tx_dat4: state_nxt = burst_ok ? etx_pkg::tx_dat1 : etx_pkg::tx_idle;
         default:          state_nxt = etx_pkg::tx_idle;
      endcase
   end

   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
         state <= etx_pkg::tx_idle;
      else
         state <= state_nxt;
   end

   // Current packet, loaded on pop
   always_ff @(posedge tx_lclk)
   begin
      if (pop)
         cur_pkt <= head_pkt;
   end

   // ######################################
   // Word select
   // ######################################

   always_comb
   begin
      link_word.frame = (state != etx_pkg::tx_idle);
      unique case (state)
         etx_pkg::tx_hdr1: link_word.data = header[47:32];
         etx_pkg::tx_hdr2: link_word.data = header[31:16];
         etx_pkg::tx_hdr3: link_word.data = header[15:0];
         etx_pkg::tx_dat1: link_word.data = cur_pkt.data[31:16];
         etx_pkg::tx_dat2: link_word.data = cur_pkt.data[15:0];
         etx_pkg::tx_dat3: link_word.data = cur_pkt.srcaddr[31:16];
         etx_pkg::tx_dat4: link_word.data = cur_pkt.srcaddr[15:0];
         default:          link_word.data = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/etx_io.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_io (
   input  wire                  tx_lclk,
   input  wire                  reset,
   input  etx_pkg::link_word_t  link_word,
   input  wire                  txi_wr_wait,
   output logic                 txo_frame,
   output logic [15:0]          txo_data,
   output logic                 tx_wait
);

   logic       io_reset_in;
   logic       io_reset;
   logic [1:0] wait_sync;

   // ######################################
   // I/O reset synchronizer
   // ######################################

   // Asserts with reset, releases two edges later
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         io_reset_in <= 1'b1;
         io_reset    <= 1'b1;
      end
      else
      begin
         io_reset_in <= 1'b0;
         io_reset    <= io_reset_in;
      end
   end

   // ######################################
   // Output stage
   // ######################################

   // One register on frame and data
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         txo_frame <= 1'b0;
         txo_data  <= '0;
      end
      else if (io_reset)
      begin
         // Held clear until I/O reset drops
         txo_frame <= 1'b0;
         txo_data  <= '0;
      end
      else
      begin
         txo_frame <= link_word.frame;
         txo_data  <= link_word.data;
      end
   end

   // Pushback, two flops into tx_lclk
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
         wait_sync <= 2'b00;
      else
         wait_sync <= {wait_sync[0], txi_wr_wait};
   end

   // No new packet while outputs are held
   assign tx_wait = wait_sync[1] | io_reset;

endmodule

`default_nettype wire

/* hw/etx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_top #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire          tx_lclk,
   input  wire          reset,
   // Wishbone slave
   input  wire          wb_cyc,
   input  wire          wb_stb,
   input  wire          wb_we,
   input  wire [2:0]    wb_adr,
   input  wire [31:0]   wb_dat_w,
   output logic [31:0]  wb_dat_r,
   output logic         wb_ack,
   // Link pins
   input  wire          txi_wr_wait,
   output logic         txo_frame,
   output logic [15:0]  txo_data
);

   // Host port to queue
   logic                          push;
   etx_pkg::emesh_packet_t        push_pkt;
   logic                          fifo_full;
   logic [$clog2(FIFO_DEPTH):0]   fifo_count;

   // Queue to framer
   logic                          fifo_empty;
   logic                          pop;
   etx_pkg::emesh_packet_t        head_pkt;

   // Framer to I/O
   etx_pkg::link_word_t           link_word;
   logic                          tx_wait;

   etx_wb_slave #(.FIFO_DEPTH(FIFO_DEPTH)) i_wb_slave (
      .tx_lclk(tx_lclk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .fifo_full(fifo_full), .fifo_count(fifo_count),
      .tx_wait(tx_wait), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .push(push), .push_pkt(push_pkt)
   );

   etx_packet_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_packet_fifo (
      .tx_lclk(tx_lclk), .reset(reset), .push(push), .push_pkt(push_pkt),
      .pop(pop), .head_pkt(head_pkt), .empty(fifo_empty), .full(fifo_full),
      .count(fifo_count)
   );

   etx_framer i_framer (
      .tx_lclk(tx_lclk), .reset(reset), .empty(fifo_empty), .head_pkt(head_pkt),
      .tx_wait(tx_wait), .pop(pop), .link_word(link_word)
   );

   etx_io i_io (
      .tx_lclk(tx_lclk), .reset(reset), .link_word(link_word),
      .txi_wr_wait(txi_wr_wait), .txo_frame(txo_frame), .txo_data(txo_data),
      .tx_wait(tx_wait)
   );

endmodule

`default_nettype wire

/* bench/etx_model.svh */
`ifndef ETX_MODEL_SVH
`define ETX_MODEL_SVH

// Expected link words, filled here and drained by the monitor
logic [15:0]            exp_q[$];
int                     exp_frames;
int                     exp_words;
// Last packet of an open burst chain
etx_pkg::emesh_packet_t last_pkt;
logic                   chain_open;

// 48-bit header, most significant end first
function automatic logic [47:0] header_of(input etx_pkg::emesh_packet_t p);
   return {~p.write, 7'd0, p.ctrlmode, p.dstaddr, p.datamode, p.write, 1'b1};
endfunction

// Burst rule between two consecutive packets
function automatic logic chains_to(input etx_pkg::emesh_packet_t prev,
                                   input etx_pkg::emesh_packet_t cur);
   return prev.write && cur.write
       && (prev.ctrlmode == cur.ctrlmode)
       && (prev.datamode == cur.datamode)
       && (cur.dstaddr == prev.dstaddr + 32'd8);
endfunction

// Framer went idle, next packet needs a header
task automatic break_chain();
   chain_open = 1'b0;
endtask

// Expand one accepted packet into words
task automatic expect_packet(input etx_pkg::emesh_packet_t p);
   logic [47:0] hdr;
   hdr = header_of(p);
   if (!(chain_open && chains_to(last_pkt, p)))
   begin
      // New frame, three header words
      exp_q.push_back(hdr[47:32]);
      exp_q.push_back(hdr[31:16]);
      exp_q.push_back(hdr[15:0]);
      exp_frames++;
      exp_words += 3;
   end
   // Data phase
   exp_q.push_back(p.data[31:16]);
   exp_q.push_back(p.data[15:0]);
   exp_q.push_back(p.srcaddr[31:16]);
   exp_q.push_back(p.srcaddr[15:0]);
   exp_words += 4;
   last_pkt   = p;
   chain_open = 1'b1;
endtask

`endif

/* bench/etx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module etx_tb;

   localparam int FIFO_DEPTH  = 4;
   localparam int ACK_LIMIT   = 40;
   localparam int DRAIN_LIMIT = 400;

   logic        tx_lclk;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [2:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        txi_wr_wait;
   logic        txo_frame;
   logic [15:0] txo_data;

   // Run bookkeeping
   int          errors;
   int          err_mark;
   int          tests_run;
   int          tests_failed;
   int          frames_seen;
   int          words_seen;
   int          rng_init;
   int          i;
   int          b;
   int          n;
   logic        frame_d;
   logic        hold_check;
   logic        acked;
   logic [15:0] exp_word;
   logic [31:0] rdat;
   etx_pkg::emesh_packet_t pkt;

   `include "etx_model.svh"

   etx_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_etx_top (
      .tx_lclk(tx_lclk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .txi_wr_wait(txi_wr_wait), .txo_frame(txo_frame), .txo_data(txo_data)
   );

   // 10 ns link clock
   initial tx_lclk = 1'b0;
   always #5 tx_lclk = ~tx_lclk;

   // ######################################
   // Checks and bus helpers
   // ######################################

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("MISMATCH %0t %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic require(input logic cond, input string msg);
      assert (cond)
      else
      begin
         errors++;
         $display("ERROR %0t %s", $time, msg);
      end
   endtask

   // Raise cyc and stb on a falling edge
   task automatic start_cycle(input logic [2:0] adr, input logic we, input logic [31:0] dat);
      @(negedge tx_lclk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
   endtask

   task automatic wait_ack(input int limit, output logic got_ack);
      int k;
      got_ack = 1'b0;
      k = 0;
      while (!got_ack && k < limit)
      begin
         @(negedge tx_lclk);
         if (wb_ack)
            got_ack = 1'b1;
         k++;
      end
   endtask

   task automatic end_cycle();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic transfer(input logic [2:0] adr, input logic we, input logic [31:0] dat,
                           output logic [31:0] data_out);
      logic got;
      start_cycle(adr, we, dat);
      wait_ack(ACK_LIMIT, got);
      data_out = wb_dat_r;
      end_cycle();
      require(got, "no ack on a bus transfer within the timeout");
   endtask

   // Control word with write, datamode and ctrlmode fields
   function automatic logic [31:0] ctrl_word(input etx_pkg::emesh_packet_t p);
      return {24'd0, p.ctrlmode, 1'b0, p.datamode, p.write};
   endfunction

   task automatic write_fields(input etx_pkg::emesh_packet_t p);
      logic [31:0] unused;
      transfer(etx_pkg::reg_dstaddr, 1'b1, p.dstaddr, unused);
      transfer(etx_pkg::reg_srcaddr, 1'b1, p.srcaddr, unused);
      transfer(etx_pkg::reg_data, 1'b1, p.data, unused);
   endtask

   // Field writes and the control write that queues it
   task automatic queue_packet(input etx_pkg::emesh_packet_t p);
      logic [31:0] unused;
      write_fields(p);
      transfer(etx_pkg::reg_ctrl, 1'b1, ctrl_word(p), unused);
      expect_packet(p);
   endtask

   // Follow mode gives a burst candidate after prev
   function automatic etx_pkg::emesh_packet_t random_packet(
      input etx_pkg::emesh_packet_t prev, input logic follow);
      etx_pkg::emesh_packet_t p;
      p          = '0;
      p.write    = $urandom_range(0, 1);
      p.datamode = etx_pkg::datamode_t'($urandom_range(0, 3));
      p.ctrlmode = $urandom_range(0, 15);
      p.dstaddr  = $urandom;
      p.data     = $urandom;
      p.srcaddr  = $urandom;
      if (follow)
      begin
         p.write    = 1'b1;
         p.datamode = prev.datamode;
         p.ctrlmode = prev.ctrlmode;
         p.dstaddr  = prev.dstaddr + 32'd8;
      end
      return p;
   endfunction

   // Drive pushback and let the two-flop sync settle
   task automatic set_pushback(input logic level);
      @(negedge tx_lclk);
      hold_check  = 1'b0;
      txi_wr_wait = level;
      repeat (4) @(negedge tx_lclk);
      hold_check  = level;
   endtask

   task automatic wait_drain();
      int k;
      k = 0;
      while ((exp_q.size() != 0 || txo_frame) && k < DRAIN_LIMIT)
      begin
         @(negedge tx_lclk);
         k++;
      end
      require(k < DRAIN_LIMIT, "link did not drain within the timeout");
      exp_q.delete();
   endtask

   task automatic report_test(input string name);
      compare_value("frame count", frames_seen, exp_frames);
      tests_run++;
      if (errors == err_mark)
         $display("%s: pass", name);
      else
      begin
         tests_failed++;
         $display("%s: FAIL, %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // ######################################
   // Link monitor
   // ######################################

   always @(negedge tx_lclk)
   begin
      if (!reset)
      begin
         if (txo_frame && !frame_d)
            frames_seen++;
         if (txo_frame)
         begin
            words_seen++;
            require(!hold_check, "word framed while pushback was held");
            require(exp_q.size() != 0, "framed word with no expected word left");
            if (exp_q.size() != 0)
            begin
               exp_word = exp_q.pop_front();
               compare_value("txo_data", txo_data, exp_word);
            end
         end
         frame_d = txo_frame;
      end
   end

   // ######################################
   // Test sequence
   // ######################################

   initial
   begin
      // Inputs idle from time zero
      reset       = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      txi_wr_wait = 1'b0;
      errors      = 0;
      err_mark    = 0;
      tests_run   = 0;
      tests_failed = 0;
      frames_seen = 0;
      words_seen  = 0;
      frame_d     = 1'b0;
      hold_check  = 1'b0;
      exp_frames  = 0;
      exp_words   = 0;
      chain_open  = 1'b0;
      pkt         = '0;
      // Seed the random stream once
      rng_init    = $urandom(32'h125a_28cd);
      repeat (8) @(posedge tx_lclk);
      @(negedge tx_lclk);
      reset = 1'b0;

      // Quiet outputs after reset
      repeat (16)
      begin
         @(negedge tx_lclk);
         compare_value("txo_frame", txo_frame, 1'b0);
         compare_value("txo_data", txo_data, 16'd0);
         compare_value("wb_ack", wb_ack, 1'b0);
      end
      report_test("reset quiet");

      // One packet at a time and never a burst
      for (i = 0; i < 6; i++)
      begin
         pkt = random_packet(pkt, 1'b0);
         break_chain();
         queue_packet(pkt);
         wait_drain();
      end
      report_test("single packets");

      // Queue a full burst behind pushback
      break_chain();
      set_pushback(1'b1);
      pkt = random_packet(pkt, 1'b0);
      pkt.write = 1'b1;
      for (i = 0; i < FIFO_DEPTH; i++)
      begin
         queue_packet(pkt);
         pkt = random_packet(pkt, 1'b1);
      end
      set_pushback(1'b0);
      wait_drain();
      report_test("burst writes");

      // Field readback
      pkt = random_packet(pkt, 1'b0);
      write_fields(pkt);
      transfer(etx_pkg::reg_dstaddr, 1'b0, 32'd0, rdat);
      compare_value("dstaddr readback", rdat, pkt.dstaddr);
      transfer(etx_pkg::reg_srcaddr, 1'b0, 32'd0, rdat);
      compare_value("srcaddr readback", rdat, pkt.srcaddr);
      transfer(etx_pkg::reg_data, 1'b0, 32'd0, rdat);
      compare_value("data readback", rdat, pkt.data);
      // Status with two packets held back
      break_chain();
      set_pushback(1'b1);
      queue_packet(pkt);
      pkt = random_packet(pkt, 1'b0);
      queue_packet(pkt);
      // Control fields of the last queued packet
      transfer(etx_pkg::reg_ctrl, 1'b0, 32'd0, rdat);
      compare_value("ctrl readback", rdat, ctrl_word(pkt));
      transfer(etx_pkg::reg_status, 1'b0, 32'd0, rdat);
      compare_value("status", rdat, 32'h0000_0102);
      set_pushback(1'b0);
      wait_drain();
      transfer(etx_pkg::reg_status, 1'b0, 32'd0, rdat);
      compare_value("status", rdat, 32'h0000_0000);
      report_test("register readback");

      // Fill the queue and add one control write too many
      break_chain();
      set_pushback(1'b1);
      pkt = random_packet(pkt, 1'b0);
      for (i = 0; i < FIFO_DEPTH; i++)
      begin
         queue_packet(pkt);
         pkt = random_packet(pkt, i[0]);
      end
      write_fields(pkt);
      start_cycle(etx_pkg::reg_ctrl, 1'b1, ctrl_word(pkt));
      wait_ack(12, acked);
      require(!acked, "control write acked while the queue was full");
      // Release pushback with the write still pending
      hold_check  = 1'b0;
      txi_wr_wait = 1'b0;
      wait_ack(ACK_LIMIT, acked);
      end_cycle();
      require(acked, "control write not acked after pushback release");
      expect_packet(pkt);
      wait_drain();
      report_test("back-pressure");

      // Random batches behind pushback
      for (b = 0; b < 12; b++)
      begin
         n = $urandom_range(1, FIFO_DEPTH);
         break_chain();
         set_pushback(1'b1);
         for (i = 0; i < n; i++)
         begin
            pkt = random_packet(pkt, $urandom_range(0, 1));
            queue_packet(pkt);
         end
         set_pushback(1'b0);
         wait_drain();
      end
      compare_value("framed word count", words_seen, exp_words);
      report_test("random mix");

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
hw/etx_pkg.sv
hw/etx_wb_slave.sv
hw/etx_packet_fifo.sv
hw/etx_framer.sv
hw/etx_io.sv
hw/etx_top.sv
bench/etx_tb.sv
